// File: build.f
rtl/acc_pkg.sv
rtl/acc_loop_counter.sv
rtl/acc_ctrl_fsm.sv
rtl/acc_fetch_unit.sv
rtl/acc_mac_unit.sv
rtl/acc_ofm_writer.sv
rtl/acc_top.sv
test/acc_tb_assert.sv
test/acc_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = acc_tb
FILELIST  = build.f
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: test/acc_tests.txt
// hex words: number of tests, then per test ifm_base wgt_base ofm_base cfg_ci cfg_co,
// then ifm words, wgt words in memory order (co-major), expected ofm words
00000003
// one word, mixed-sign lanes
00000100 00000200 00000300 00000001 00000001
02FF7F80
03FE0201
86000000
// four input words, three output channels
00000400 00000500 00000600 00000004 00000003
01020304 FF01FE02 10F00000 7F807F80
01010101 02020202 01FF0000 01010101
FFFFFFFF 03FD0000 00000000 80000000
7F000000 00000080 02020202 80808080
28000000 70C0FFFF 7F000000
// two input words, two output channels, negative second result
00001100 00001200 00001300 00000002 00000002
05FB0A00 81017FFE
0101FF00 FF000102
80807F7F 7F7F8080
F0000000 F487FFFF

// File: test/acc_tb.sv
// acc testbench runs vector-driven convolution jobs against a memory model with random delays
`timescale 1ns/100ps

module acc_tb;

  import acc_pkg::*;

  localparam int ADDR_W     = ADDR_WIDTH_DEF;
  localparam int CNT_W      = CNT_WIDTH_DEF;
  localparam int CLK_HALF   = 20;
  localparam int DRIVE_DLY  = 2;
  localparam int MAX_TESTS  = 8;
  localparam int TV_DEPTH   = 256;
  localparam int WAIT_LIMIT = 50;
  localparam int RUN_LIMIT  = 4000;

  logic              ap_clk = 1'b0;
  logic              ap_rst_n = 1'b0;
  logic              ap_start = 1'b0;
  logic              ap_idle;
  logic              ap_ready;
  logic              ap_done;
  logic [ADDR_W-1:0] ifm_addr_base = '0;
  logic [ADDR_W-1:0] wgt_addr_base = '0;
  logic [ADDR_W-1:0] ofm_addr_base = '0;
  logic [CNT_W-1:0]  cfg_ci = '0;
  logic [CNT_W-1:0]  cfg_co = '0;
  logic              ifm_rd_req;
  logic [ADDR_W-1:0] ifm_rd_addr;
  logic              ifm_rd_valid = 1'b0;
  word_t             ifm_rd_data = '0;
  logic              wgt_rd_req;
  logic [ADDR_W-1:0] wgt_rd_addr;
  logic              wgt_rd_valid = 1'b0;
  word_t             wgt_rd_data = '0;
  logic              ofm_wr_req;
  logic [ADDR_W-1:0] ofm_wr_addr;
  word_t             ofm_wr_data;
  logic              ofm_wr_ack = 1'b0;

  word_t             tv [TV_DEPTH];
  int                num_tests;
  logic [ADDR_W-1:0] t_ifm_base [MAX_TESTS];
  logic [ADDR_W-1:0] t_wgt_base [MAX_TESTS];
  logic [ADDR_W-1:0] t_ofm_base [MAX_TESTS];
  int                t_ci [MAX_TESTS];
  int                t_co [MAX_TESTS];
  int                t_exp_off [MAX_TESTS];
  word_t             ifm_mem [logic [ADDR_W-1:0]];
  word_t             wgt_mem [logic [ADDR_W-1:0]];
  word_t             ofm_mem [logic [ADDR_W-1:0]];

  integer            seed = 32'hb72e;
  int                cur_test = 0;
  int                exp_k = 0;
  int                exp_co = 0;
  int                exp_wco = 0;
  int                ready_count = 0;
  int                done_count = 0;
  int                ifm_wait = 0;
  int                wgt_wait = 0;
  int                ofm_wait = 0;
  logic [ADDR_W-1:0] ifm_pend_addr;
  logic [ADDR_W-1:0] wgt_pend_addr;
  logic              ifm_req_s;
  logic              wgt_req_s;
  logic              ofm_req_s;
  logic [ADDR_W-1:0] ifm_addr_s;
  logic [ADDR_W-1:0] wgt_addr_s;
  logic [ADDR_W-1:0] ofm_addr_s;
  word_t             ofm_data_s;
  int                t;
  bit                ready_at_done;

  acc_top #(
    .ADDR_WIDTH (ADDR_W),
    .CNT_WIDTH  (CNT_W)
  ) UUT (.*);

  always #CLK_HALF ap_clk = ~ap_clk;

  task automatic fail_now(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("FAILED at %0d ns: %s, got %08h, expected %08h", $time, what, got, expected);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // response delay of 1 to 6 cycles
  function automatic int rand_delay();
    logic [31:0] r;
    r = $random(seed);
    return 1 + int'(r % 32'd6);
  endfunction

  task automatic load_vectors();
    int p;
    int k;
    int n;
    $readmemh("test/acc_tests.txt", tv);
    if ($isunknown(tv[0])) fail_now("test vector file is missing or empty");
    num_tests = int'(tv[0]);
    if (num_tests < 1 || num_tests > MAX_TESTS) fail_now("bad number of tests in vector file");
    p = 1;
    for (n = 0; n < num_tests; n++) begin
      t_ifm_base[n] = tv[p];
      t_wgt_base[n] = tv[p+1];
      t_ofm_base[n] = tv[p+2];
      t_ci[n] = int'(tv[p+3]);
      t_co[n] = int'(tv[p+4]);
      p = p + 5;
      for (k = 0; k < t_ci[n]; k++) begin
        ifm_mem[t_ifm_base[n] + ADDR_W'(4 * k)] = tv[p];
        p++;
      end
      for (k = 0; k < t_ci[n] * t_co[n]; k++) begin
        wgt_mem[t_wgt_base[n] + ADDR_W'(4 * k)] = tv[p];
        p++;
      end
      t_exp_off[n] = p;
      p = p + t_co[n];
    end
  endtask

  task automatic drive_config(input int n);
    ifm_addr_base = t_ifm_base[n];
    wgt_addr_base = t_wgt_base[n];
    ofm_addr_base = t_ofm_base[n];
    cfg_ci = CNT_W'(t_ci[n]);
    cfg_co = CNT_W'(t_co[n]);
  endtask

  task automatic check_reset_state();
    check_value(32'(ap_idle), 1, "ap_idle after reset");
    check_value(32'(ap_done), 0, "ap_done after reset");
    check_value(32'(ap_ready), 0, "ap_ready after reset");
    check_value(32'(ifm_rd_req), 0, "ifm_rd_req after reset");
    check_value(32'(wgt_rd_req), 0, "wgt_rd_req after reset");
    check_value(32'(ofm_wr_req), 0, "ofm_wr_req after reset");
  endtask

  task automatic wait_for_accept();
    int cycles;
    cycles = 0;
    do begin
      @(posedge ap_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) fail_now("timed out waiting for ap_ready");
    end while (!ap_ready);
  endtask

  // last run drops ap_start once its first write shows up
  task automatic wait_for_done(input bit last, output bit ready_seen);
    int cycles;
    bit drop;
    bit seen;
    cycles = 0;
    drop = 1'b0;
    seen = 1'b0;
    ready_seen = 1'b0;
    while (!seen) begin
      @(posedge ap_clk);
      if (ap_done) begin
        seen = 1'b1;
        ready_seen = ap_ready;
      end else begin
        if (ap_ready) fail_now("a second run was accepted while the kernel was busy");
        if (last && ofm_wr_req) drop = 1'b1;
        cycles++;
        if (cycles > RUN_LIMIT) fail_now("timed out waiting for ap_done");
        #DRIVE_DLY;
        if (drop) ap_start = 1'b0;
      end
    end
  endtask

  task automatic start_tracking(input int n);
    cur_test = n;
    exp_k = 0;
    exp_co = 0;
    exp_wco = 0;
  endtask

  task automatic check_results(input int n);
    int co;
    logic [ADDR_W-1:0] a;
    check_value(exp_co, t_co[n], $sformatf("channels read in test %0d", n));
    check_value(exp_wco, t_co[n], $sformatf("ofm writes in test %0d", n));
    for (co = 0; co < t_co[n]; co++) begin
      a = t_ofm_base[n] + ADDR_W'(4 * co);
      if (!ofm_mem.exists(a)) fail_now("an output channel was never written");
      check_value(ofm_mem[a], tv[t_exp_off[n] + co],
                  $sformatf("ofm word of test %0d channel %0d", n, co));
    end
  endtask

  // memory model samples at the edge and answers just after it
  always @(posedge ap_clk) begin
    ifm_req_s  = ifm_rd_req;
    wgt_req_s  = wgt_rd_req;
    ofm_req_s  = ofm_wr_req;
    ifm_addr_s = ifm_rd_addr;
    wgt_addr_s = wgt_rd_addr;
    ofm_addr_s = ofm_wr_addr;
    ofm_data_s = ofm_wr_data;
    #DRIVE_DLY;
    ifm_rd_valid = 1'b0;
    wgt_rd_valid = 1'b0;
    ofm_wr_ack   = 1'b0;
    if (ifm_req_s) begin
      if (ifm_wait != 0) fail_now("ifm read issued before the previous one returned");
      check_value(ifm_addr_s, t_ifm_base[cur_test] + ADDR_W'(4 * exp_k), "ifm read address");
      ifm_pend_addr = ifm_addr_s;
      ifm_wait = rand_delay();
    end
    if (wgt_req_s) begin
      if (wgt_wait != 0) fail_now("wgt read issued before the previous one returned");
      check_value(wgt_addr_s,
                  t_wgt_base[cur_test] + ADDR_W'(4 * (exp_co * t_ci[cur_test] + exp_k)),
                  "wgt read address");
      wgt_pend_addr = wgt_addr_s;
      wgt_wait = rand_delay();
    end
    if (ifm_req_s || wgt_req_s) begin
      exp_k++;
      if (exp_k == t_ci[cur_test]) begin
        exp_k = 0;
        exp_co++;
      end
    end
    if (ofm_req_s) begin
      if (ofm_wait != 0) fail_now("ofm write issued before the previous one was acked");
      check_value(ofm_addr_s, t_ofm_base[cur_test] + ADDR_W'(4 * exp_wco), "ofm write address");
      ofm_mem[ofm_addr_s] = ofm_data_s;
      exp_wco++;
      ofm_wait = rand_delay();
    end
    if (ifm_wait != 0) begin
      ifm_wait--;
      if (ifm_wait == 0) begin
        ifm_rd_valid = 1'b1;
        ifm_rd_data  = ifm_mem[ifm_pend_addr];
      end
    end
    if (wgt_wait != 0) begin
      wgt_wait--;
      if (wgt_wait == 0) begin
        wgt_rd_valid = 1'b1;
        wgt_rd_data  = wgt_mem[wgt_pend_addr];
      end
    end
    if (ofm_wait != 0) begin
      ofm_wait--;
      if (ofm_wait == 0) ofm_wr_ack = 1'b1;
    end
  end

  always @(posedge ap_clk) begin
    if (ap_rst_n && ap_ready) ready_count++;
    if (ap_rst_n && ap_done) done_count++;
  end

  // protocol checker failures end the run at the next edge
  always @(posedge ap_clk) begin
    if (UUT.u_assert.fail_count != 0) fail_now("a protocol assertion failed");
  end

  initial begin
    load_vectors();
    repeat (4) @(posedge ap_clk);
    check_reset_state();
    #DRIVE_DLY;
    ap_rst_n = 1'b1;
    @(posedge ap_clk);
    check_reset_state();
    #DRIVE_DLY;
    drive_config(0);
    ap_start = 1'b1;
    wait_for_accept();
    // runs chain back to back with the next config driven right after each acceptance
    for (t = 0; t < num_tests; t++) begin
      start_tracking(t);
      #DRIVE_DLY;
      if (t + 1 < num_tests) drive_config(t + 1);
      wait_for_done(t == num_tests - 1, ready_at_done);
      check_results(t);
      check_value(32'(ready_at_done), (t + 1 < num_tests) ? 1 : 0, "acceptance on done cycle");
    end
    repeat (3) @(posedge ap_clk);
    #DRIVE_DLY;
    check_value(32'(ap_idle), 1, "ap_idle after last run");
    check_value(ready_count, num_tests, "ap_ready pulse count");
    check_value(done_count, num_tests, "ap_done pulse count");
    if (UUT.u_assert.fail_count != 0) begin
      fail_now("a protocol assertion failed during the run");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// File: test/acc_tb_assert.sv
// acc protocol checker for done pulse width, paired reads and strobes while idle
`timescale 1ns/100ps

module acc_tb_assert (
  input logic ap_clk,
  input logic ap_rst_n,
  input logic ap_idle,
  input logic ap_done,
  input logic ifm_rd_req,
  input logic wgt_rd_req,
  input logic ofm_wr_req
);

  // number of assertion failures so far
  int fail_count = 0;

  done_single_cycle: assert property (
    @(posedge ap_clk) disable iff (!ap_rst_n) ap_done |=> !ap_done
  ) else begin
    fail_count++;
    $error("ap_done stayed high for more than one cycle");
  end

  // both reads of a word pair go out on the same cycle
  reads_paired: assert property (
    @(posedge ap_clk) disable iff (!ap_rst_n) ifm_rd_req == wgt_rd_req
  ) else begin
    fail_count++;
    $error("ifm and wgt read requests not issued together");
  end

  no_strobe_when_idle: assert property (
    @(posedge ap_clk) disable iff (!ap_rst_n)
      (ifm_rd_req || wgt_rd_req || ofm_wr_req) |-> !ap_idle
  ) else begin
    fail_count++;
    $error("memory request strobe while the kernel is idle");
  end

endmodule

bind acc_top acc_tb_assert u_assert (
  .ap_clk     (ap_clk),
  .ap_rst_n   (ap_rst_n),
  .ap_idle    (ap_idle),
  .ap_done    (ap_done),
  .ifm_rd_req (ifm_rd_req),
  .wgt_rd_req (wgt_rd_req),
  .ofm_wr_req (ofm_wr_req)
);

// File: rtl/acc_top.sv
// acc top: convolution kernel core joining controller, counters, fetch, MAC and writer
`timescale 1ns/100ps

module acc_top #(
  parameter int ADDR_WIDTH = acc_pkg::ADDR_WIDTH_DEF,
  parameter int CNT_WIDTH  = acc_pkg::CNT_WIDTH_DEF
) (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  input  logic                  ap_start,
  output logic                  ap_idle,
  output logic                  ap_ready,
  output logic                  ap_done,
  input  logic [ADDR_WIDTH-1:0] ifm_addr_base,
  input  logic [ADDR_WIDTH-1:0] wgt_addr_base,
  input  logic [ADDR_WIDTH-1:0] ofm_addr_base,
  input  logic [CNT_WIDTH-1:0]  cfg_ci,
  input  logic [CNT_WIDTH-1:0]  cfg_co,
  output logic                  ifm_rd_req,
  output logic [ADDR_WIDTH-1:0] ifm_rd_addr,
  input  logic                  ifm_rd_valid,
  input  acc_pkg::word_t        ifm_rd_data,
  output logic                  wgt_rd_req,
  output logic [ADDR_WIDTH-1:0] wgt_rd_addr,
  input  logic                  wgt_rd_valid,
  input  acc_pkg::word_t        wgt_rd_data,
  output logic                  ofm_wr_req,
  output logic [ADDR_WIDTH-1:0] ofm_wr_addr,
  output acc_pkg::word_t        ofm_wr_data,
  input  logic                  ofm_wr_ack
);

  import acc_pkg::*;

  logic                   fetch_start;
  logic                   fetch_done;
  logic                   mac_en;
  logic                   mac_clear;
  logic                   write_start;
  logic                   write_done;
  logic                   cnt_clear;
  logic                   step;
  logic                   ci_last;
  logic                   co_last;
  logic [CNT_WIDTH-1:0]   ci_idx;
  logic [CNT_WIDTH-1:0]   co_idx;
  logic [2*CNT_WIDTH-1:0] wgt_idx;
  word_t                  ifm_word;
  word_t                  wgt_word;
  word_t                  acc_value;

  acc_ctrl_fsm u_ctrl (
    .ap_clk      (ap_clk),
    .ap_rst_n    (ap_rst_n),
    .ap_start    (ap_start),
    .fetch_done  (fetch_done),
    .write_done  (write_done),
    .ci_last     (ci_last),
    .co_last     (co_last),
    .ap_idle     (ap_idle),
    .ap_ready    (ap_ready),
    .ap_done     (ap_done),
    .fetch_start (fetch_start),
    .mac_en      (mac_en),
    .mac_clear   (mac_clear),
    .write_start (write_start),
    .cnt_clear   (cnt_clear),
    .step        (step)
  );

  acc_loop_counter #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_cnt (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .cnt_clear (cnt_clear),
    .step      (step),
    .cfg_ci    (cfg_ci),
    .cfg_co    (cfg_co),
    .ci_idx    (ci_idx),
    .co_idx    (co_idx),
    .wgt_idx   (wgt_idx),
    .ci_last   (ci_last),
    .co_last   (co_last)
  );

  // configuration is taken on the acceptance edge
  acc_fetch_unit #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .CNT_WIDTH  (CNT_WIDTH)
  ) u_fetch (
    .ap_clk        (ap_clk),
    .ap_rst_n      (ap_rst_n),
    .cfg_load      (ap_ready),
    .ifm_addr_base (ifm_addr_base),
    .wgt_addr_base (wgt_addr_base),
    .fetch_start   (fetch_start),
    .ci_idx        (ci_idx),
    .wgt_idx       (wgt_idx),
    .ifm_rd_req    (ifm_rd_req),
    .ifm_rd_addr   (ifm_rd_addr),
    .ifm_rd_valid  (ifm_rd_valid),
    .ifm_rd_data   (ifm_rd_data),
    .wgt_rd_req    (wgt_rd_req),
    .wgt_rd_addr   (wgt_rd_addr),
    .wgt_rd_valid  (wgt_rd_valid),
    .wgt_rd_data   (wgt_rd_data),
    .fetch_done    (fetch_done),
    .ifm_word      (ifm_word),
    .wgt_word      (wgt_word)
  );

  acc_mac_unit u_mac (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .mac_en    (mac_en),
    .mac_clear (mac_clear),
    .ifm_word  (ifm_word),
    .wgt_word  (wgt_word),
    .acc_value (acc_value)
  );

  acc_ofm_writer #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .CNT_WIDTH  (CNT_WIDTH)
  ) u_wr (
    .ap_clk        (ap_clk),
    .ap_rst_n      (ap_rst_n),
    .cfg_load      (ap_ready),
    .ofm_addr_base (ofm_addr_base),
    .write_start   (write_start),
    .co_idx        (co_idx),
    .acc_value     (acc_value),
    .ofm_wr_ack    (ofm_wr_ack),
    .ofm_wr_req    (ofm_wr_req),
    .ofm_wr_addr   (ofm_wr_addr),
    .ofm_wr_data   (ofm_wr_data),
    .write_done    (write_done)
  );

endmodule

// File: rtl/acc_ofm_writer.sv
// acc ofm writer: byte-reverses a channel result and writes it with a single-word strobe
`timescale 1ns/100ps

module acc_ofm_writer #(
  parameter int ADDR_WIDTH = acc_pkg::ADDR_WIDTH_DEF,
  parameter int CNT_WIDTH  = acc_pkg::CNT_WIDTH_DEF
) (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  input  logic                  cfg_load,
  input  logic [ADDR_WIDTH-1:0] ofm_addr_base,
  input  logic                  write_start,
  input  logic [CNT_WIDTH-1:0]  co_idx,
  input  acc_pkg::word_t        acc_value,
  input  logic                  ofm_wr_ack,
  output logic                  ofm_wr_req,
  output logic [ADDR_WIDTH-1:0] ofm_wr_addr,
  output acc_pkg::word_t        ofm_wr_data,
  output logic                  write_done
);

  import acc_pkg::*;

  logic [ADDR_WIDTH-1:0] ofm_base_q;
  logic                  pending_q;

  always_ff @(posedge ap_clk) begin
    if (cfg_load) begin
      ofm_base_q <= ofm_addr_base;
    end
    if (write_start) begin
      ofm_wr_addr <= ofm_base_q + (ADDR_WIDTH'(co_idx) << 2);
      ofm_wr_data <= byte_rev(acc_value);
    end
  end

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      ofm_wr_req <= 1'b0;
      pending_q  <= 1'b0;
      write_done <= 1'b0;
    end else begin
      ofm_wr_req <= write_start;
      write_done <= pending_q && ofm_wr_ack;
      // wait here as long as memory withholds the ack
      if (write_start) begin
        pending_q <= 1'b1;
      end else if (ofm_wr_ack) begin
        pending_q <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/acc_mac_unit.sv
// acc MAC unit: four-lane signed 8-bit dot product into a wrapping 32-bit accumulator
`timescale 1ns/100ps

module acc_mac_unit (
  input  logic           ap_clk,
  input  logic           ap_rst_n,
  input  logic           mac_en,
  input  logic           mac_clear,
  input  acc_pkg::word_t ifm_word,
  input  acc_pkg::word_t wgt_word,
  output acc_pkg::word_t acc_value
);

  import acc_pkg::*;

  logic signed [2*LANE_BITS-1:0] prod [LANES];
  logic signed [WORD_BITS-1:0]   dot_sum;

  // lane 0 sits in the low byte
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      prod[i] = lane_t'(ifm_word[i*LANE_BITS +: LANE_BITS]) *
                lane_t'(wgt_word[i*LANE_BITS +: LANE_BITS]);
    end
  end

  always_comb begin
    dot_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      dot_sum = dot_sum + prod[i];
    end
  end

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      acc_value <= '0;
    end else if (mac_en) begin
      if (mac_clear) begin
        acc_value <= word_t'(dot_sum);
      end else begin
        acc_value <= acc_value + word_t'(dot_sum);
      end
    end
  end

endmodule

// File: rtl/acc_fetch_unit.sv
// acc fetch unit: issues paired ifm and wgt word reads and captures byte-reversed data
`timescale 1ns/100ps

module acc_fetch_unit #(
  parameter int ADDR_WIDTH = acc_pkg::ADDR_WIDTH_DEF,
  parameter int CNT_WIDTH  = acc_pkg::CNT_WIDTH_DEF
) (
  input  logic                   ap_clk,
  input  logic                   ap_rst_n,
  input  logic                   cfg_load,
  input  logic [ADDR_WIDTH-1:0]  ifm_addr_base,
  input  logic [ADDR_WIDTH-1:0]  wgt_addr_base,
  input  logic                   fetch_start,
  input  logic [CNT_WIDTH-1:0]   ci_idx,
  input  logic [2*CNT_WIDTH-1:0] wgt_idx,
  output logic                   ifm_rd_req,
  output logic [ADDR_WIDTH-1:0]  ifm_rd_addr,
  input  logic                   ifm_rd_valid,
  input  acc_pkg::word_t         ifm_rd_data,
  output logic                   wgt_rd_req,
  output logic [ADDR_WIDTH-1:0]  wgt_rd_addr,
  input  logic                   wgt_rd_valid,
  input  acc_pkg::word_t         wgt_rd_data,
  output logic                   fetch_done,
  output acc_pkg::word_t         ifm_word,
  output acc_pkg::word_t         wgt_word
);

  import acc_pkg::*;

  logic [ADDR_WIDTH-1:0] ifm_base_q;
  logic [ADDR_WIDTH-1:0] wgt_base_q;
  logic                  busy_q;
  logic                  ifm_got_q;
  logic                  wgt_got_q;
  logic                  ifm_have;
  logic                  wgt_have;

  always_ff @(posedge ap_clk) begin
    if (cfg_load) begin
      ifm_base_q <= ifm_addr_base;
      wgt_base_q <= wgt_addr_base;
    end
  end

  // both reads go out together, word addresses are byte offsets of 4
  assign ifm_rd_req  = fetch_start;
  assign wgt_rd_req  = fetch_start;
  assign ifm_rd_addr = ifm_base_q + (ADDR_WIDTH'(ci_idx) << 2);
  assign wgt_rd_addr = wgt_base_q + (ADDR_WIDTH'(wgt_idx) << 2);

  assign ifm_have = ifm_got_q || ifm_rd_valid;
  assign wgt_have = wgt_got_q || wgt_rd_valid;

  always_ff @(posedge ap_clk) begin
    if (ifm_rd_valid) ifm_word <= byte_rev(ifm_rd_data);
    if (wgt_rd_valid) wgt_word <= byte_rev(wgt_rd_data);
  end

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      busy_q     <= 1'b0;
      ifm_got_q  <= 1'b0;
      wgt_got_q  <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      if (fetch_start) begin
        busy_q    <= 1'b1;
        ifm_got_q <= 1'b0;
        wgt_got_q <= 1'b0;
      end else if (busy_q) begin
        ifm_got_q <= ifm_have;
        wgt_got_q <= wgt_have;
        // done the cycle after whichever word lands last
        if (ifm_have && wgt_have) begin
          busy_q     <= 1'b0;
          fetch_done <= 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/acc_ctrl_fsm.sv
// acc controller: block-level FSM sequencing fetch, accumulate and write per channel
`timescale 1ns/100ps

module acc_ctrl_fsm (
  input  logic ap_clk,
  input  logic ap_rst_n,
  input  logic ap_start,
  input  logic fetch_done,
  input  logic write_done,
  input  logic ci_last,
  input  logic co_last,
  output logic ap_idle,
  output logic ap_ready,
  output logic ap_done,
  output logic fetch_start,
  output logic mac_en,
  output logic mac_clear,
  output logic write_start,
  output logic cnt_clear,
  output logic step
);

  import acc_pkg::*;

  acc_state_e state_q;
  acc_state_e state_d;
  logic       first_q;

  // done cycle already counts as idle so a new run may start there
  assign ap_idle   = (state_q == ST_IDLE) || (state_q == ST_DONE);
  assign ap_ready  = ap_idle && ap_start;
  assign ap_done   = (state_q == ST_DONE);
  assign cnt_clear = ap_ready;
  assign mac_en    = (state_q == ST_MAC);
  assign mac_clear = first_q;

  // last word of a channel steps after the write, keeping co_idx for the address
  assign step = (mac_en && !ci_last) || ((state_q == ST_WRITE) && write_done);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_DONE: begin
        state_d = ap_start ? ST_FETCH : ST_IDLE;
      end
      ST_FETCH: begin
        if (fetch_done) state_d = ST_MAC;
      end
      ST_MAC: begin
        state_d = ci_last ? ST_WRITE : ST_FETCH;
      end
      ST_WRITE: begin
        if (write_done) state_d = co_last ? ST_DONE : ST_FETCH;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      state_q     <= ST_IDLE;
      fetch_start <= 1'b0;
      write_start <= 1'b0;
      first_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      fetch_start <= (state_d == ST_FETCH) && (state_q != ST_FETCH);
      write_start <= (state_d == ST_WRITE) && (state_q != ST_WRITE);
      // first word of each channel loads instead of adds
      if (ap_ready || ((state_q == ST_WRITE) && write_done)) begin
        first_q <= 1'b1;
      end else if (mac_en) begin
        first_q <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/acc_loop_counter.sv
// acc loop counter: input and output channel indices, flat weight index and last flags
`timescale 1ns/100ps

module acc_loop_counter #(
  parameter int CNT_WIDTH = acc_pkg::CNT_WIDTH_DEF
) (
  input  logic                   ap_clk,
  input  logic                   ap_rst_n,
  input  logic                   cnt_clear,
  input  logic                   step,
  input  logic [CNT_WIDTH-1:0]   cfg_ci,
  input  logic [CNT_WIDTH-1:0]   cfg_co,
  output logic [CNT_WIDTH-1:0]   ci_idx,
  output logic [CNT_WIDTH-1:0]   co_idx,
  output logic [2*CNT_WIDTH-1:0] wgt_idx,
  output logic                   ci_last,
  output logic                   co_last
);

  logic [CNT_WIDTH-1:0] ci_cnt_q;
  logic [CNT_WIDTH-1:0] co_cnt_q;

  always_ff @(posedge ap_clk) begin
    if (cnt_clear) begin
      ci_cnt_q <= cfg_ci;
      co_cnt_q <= cfg_co;
    end
  end

  assign ci_last = (ci_idx == ci_cnt_q - 1'b1);
  assign co_last = (co_idx == co_cnt_q - 1'b1);

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      ci_idx  <= '0;
      co_idx  <= '0;
      wgt_idx <= '0;
    end else if (cnt_clear) begin
      ci_idx  <= '0;
      co_idx  <= '0;
      wgt_idx <= '0;
    end else if (step) begin
      if (ci_last) begin
        ci_idx <= '0;
        co_idx <= co_idx + 1'b1;
      end else begin
        ci_idx <= ci_idx + 1'b1;
      end
      // weights are stored co-major, so the flat index just counts words
      wgt_idx <= wgt_idx + 1'b1;
    end
  end

endmodule

// File: rtl/acc_pkg.sv
// acc package: word and lane types, sizing defaults and controller states
package acc_pkg;

  localparam int WORD_BITS = 32;
  localparam int LANE_BITS = 8;
  localparam int LANES     = WORD_BITS / LANE_BITS;

  localparam int ADDR_WIDTH_DEF = 32;
  localparam int CNT_WIDTH_DEF  = 8;

  typedef logic [WORD_BITS-1:0]        word_t;
  typedef logic signed [LANE_BITS-1:0] lane_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_MAC,
    ST_WRITE,
    ST_DONE
  } acc_state_e;

  // memory keeps words little-endian, swap byte order
  function automatic word_t byte_rev(input word_t w);
    word_t r;
    for (int b = 0; b < LANES; b++) begin
      r[b*LANE_BITS +: LANE_BITS] = w[(LANES-1-b)*LANE_BITS +: LANE_BITS];
    end
    return r;
  endfunction

endpackage
